// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_uart_cmd -o tb_uart_cmd

out=$(./obj_dir/tb_uart_cmd)
echo "$out"
echo "$out" | grep -qx "Finished with no errors"

// ==== src/byte_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_buffer (
	input wire logic clk,
	input wire logic arst_n,
	input wire uart_cmd_pkg::buf_req_t buf_req,
	output uart_cmd_pkg::buf_rsp_t buf_rsp
);

	logic [7:0] mem [uart_cmd_pkg::BUF_DEPTH];
	logic [uart_cmd_pkg::BUF_AW:0] count;
	logic full;
	logic do_append;

	// Depth is a power of two, so the top count bit marks full
	assign full = count[uart_cmd_pkg::BUF_AW];
	assign do_append = buf_req.append & ~buf_req.clear & ~full;

	assign buf_rsp = '{rd_data: mem[buf_req.rd_idx], count: count, full: full};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			count <= '0;
		else if (buf_req.clear)
			count <= '0;
		else if (do_append)
			count <= count + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (do_append)
			mem[count[uart_cmd_pkg::BUF_AW-1:0]] <= buf_req.data;
	end

endmodule

`default_nettype wire

// ==== src/cmd_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_ctrl (
	input wire logic clk,
	input wire logic arst_n,
	input wire uart_cmd_pkg::byte_beat_t rx_beat,
	output uart_cmd_pkg::byte_beat_t tx_beat,
	input wire logic tx_ready,
	output uart_cmd_pkg::buf_req_t buf_req,
	input wire uart_cmd_pkg::buf_rsp_t buf_rsp,
	output logic [7:0] leds
);

	uart_cmd_pkg::ctrl_state_t state;
	uart_cmd_pkg::opcode_t opcode;
	logic [uart_cmd_pkg::BUF_AW-1:0] rd_idx;
	logic tx_valid;
	logic [7:0] tx_data;
	logic last_entry;

	assign opcode = uart_cmd_pkg::opcode_t'(rx_beat.data);
	assign tx_beat = '{valid: tx_valid, data: tx_data};
	assign last_entry = ({1'b0, rd_idx} == buf_rsp.count - 1'b1);

	////////////////////////////////////////////////////////////
	// Buffer requests, acted on at the next edge
	////////////////////////////////////////////////////////////

	always_comb begin
		buf_req.append = rx_beat.valid && state == uart_cmd_pkg::ST_STORE &&
			opcode != uart_cmd_pkg::OP_END;
		buf_req.clear = rx_beat.valid && state == uart_cmd_pkg::ST_OPCODE &&
			opcode == uart_cmd_pkg::OP_CLEAR;
		buf_req.data = rx_beat.data;
		buf_req.rd_idx = rd_idx;
	end

	////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= uart_cmd_pkg::ST_OPCODE;
			leds <= 8'd0;
			rd_idx <= '0;
			tx_valid <= 1'b0;
		end else begin
			case (state)
				uart_cmd_pkg::ST_OPCODE: begin
					if (rx_beat.valid) begin
						case (opcode)
							uart_cmd_pkg::OP_LED: state <= uart_cmd_pkg::ST_LED_ARG;
							uart_cmd_pkg::OP_STORE: state <= uart_cmd_pkg::ST_STORE;
							uart_cmd_pkg::OP_CLEAR: leds <= 8'd0;
							uart_cmd_pkg::OP_READBACK: begin
								// Nothing to send from an empty buffer
								if (buf_rsp.count != '0) begin
									rd_idx <= '0;
									state <= uart_cmd_pkg::ST_READBACK;
								end
							end
							// OP_END and unknown codes fall through
							default: ;
						endcase
					end
				end
				uart_cmd_pkg::ST_LED_ARG: begin
					if (rx_beat.valid) begin
						leds <= rx_beat.data;
						state <= uart_cmd_pkg::ST_OPCODE;
					end
				end
				uart_cmd_pkg::ST_STORE: begin
					if (rx_beat.valid && opcode == uart_cmd_pkg::OP_END)
						state <= uart_cmd_pkg::ST_OPCODE;
				end
				uart_cmd_pkg::ST_READBACK: begin
					// Incoming bytes are dropped while replaying
					if (!tx_valid) begin
						tx_valid <= 1'b1;
					end else if (tx_ready) begin
						tx_valid <= 1'b0;
						if (last_entry)
							state <= uart_cmd_pkg::ST_OPCODE;
						else
							rd_idx <= rd_idx + 1'b1;
					end
				end
				default: state <= uart_cmd_pkg::ST_OPCODE;
			endcase
		end
	end

	// Byte captured when presented, held until uart_tx takes it
	always_ff @(posedge clk) begin
		if (state == uart_cmd_pkg::ST_READBACK && !tx_valid)
			tx_data <= buf_rsp.rd_data;
	end

endmodule

`default_nettype wire

// ==== src/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

	////////////////////////////////////////////////////////////
	// Serial timing and buffer geometry
	////////////////////////////////////////////////////////////

	// Fixed baud divider, clocks per serial bit
	localparam logic [15:0] CLKS_PER_BIT = 16'd16;

	localparam int BUF_DEPTH = 16;
	localparam int BUF_AW = 4;

	////////////////////////////////////////////////////////////
	// Command set and control states
	////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		OP_END      = 8'd0,
		OP_LED      = 8'd1,
		OP_STORE    = 8'd2,
		OP_CLEAR    = 8'd3,
		OP_READBACK = 8'd4
	} opcode_t;

	typedef enum logic [1:0] {
		ST_OPCODE,
		ST_LED_ARG,
		ST_STORE,
		ST_READBACK
	} ctrl_state_t;

	////////////////////////////////////////////////////////////
	// Internal byte paths
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_beat_t;

	typedef struct packed {
		logic              append;
		logic              clear;
		logic [7:0]        data;
		logic [BUF_AW-1:0] rd_idx;
	} buf_req_t;

	typedef struct packed {
		logic [7:0]      rd_data;
		logic [BUF_AW:0] count;
		logic            full;
	} buf_rsp_t;

endpackage

`default_nettype wire

// ==== src/uart_cmd_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_top (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic rxd,
	output wire logic txd,
	output wire logic [7:0] leds
);

	wire uart_cmd_pkg::byte_beat_t rx_beat;
	wire uart_cmd_pkg::byte_beat_t tx_beat;
	wire logic tx_ready;
	wire uart_cmd_pkg::buf_req_t buf_req;
	wire uart_cmd_pkg::buf_rsp_t buf_rsp;

	////////////////////////////////////////////////////////////
	// Serial front end
	////////////////////////////////////////////////////////////

	uart_rx uart_rx_inst (
		.clk(clk),
		.arst_n(arst_n),
		.rxd(rxd),
		.rx_beat(rx_beat)
	);

	uart_tx uart_tx_inst (
		.clk(clk),
		.arst_n(arst_n),
		.tx_beat(tx_beat),
		.tx_ready(tx_ready),
		.txd(txd)
	);

	////////////////////////////////////////////////////////////
	// Command handling and string storage
	////////////////////////////////////////////////////////////

	cmd_ctrl cmd_ctrl_inst (
		.clk(clk),
		.arst_n(arst_n),
		.rx_beat(rx_beat),
		.tx_beat(tx_beat),
		.tx_ready(tx_ready),
		.buf_req(buf_req),
		.buf_rsp(buf_rsp),
		.leds(leds)
	);

	byte_buffer byte_buffer_inst (
		.clk(clk),
		.arst_n(arst_n),
		.buf_req(buf_req),
		.buf_rsp(buf_rsp)
	);

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic rxd,
	output uart_cmd_pkg::byte_beat_t rx_beat
);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_WAIT
	} rx_state_t;

	rx_state_t state;
	logic rxd_meta;
	logic rxd_sync;
	logic [15:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic beat_valid;
	logic bit_end;
	logic half_end;

	assign bit_end = (clk_cnt == uart_cmd_pkg::CLKS_PER_BIT - 16'd1);
	assign half_end = (clk_cnt == (uart_cmd_pkg::CLKS_PER_BIT >> 1) - 16'd1);

	// Shift register stays stable until the next frame's first data bit
	assign rx_beat = '{valid: beat_valid, data: shift};

	// Line idles high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RX_IDLE;
			clk_cnt <= 16'd0;
			bit_idx <= 3'd0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= 1'b0;
			clk_cnt <= clk_cnt + 16'd1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= 16'd0;
					if (!rxd_sync)
						state <= RX_START;
				end
				RX_START: begin
					// Middle of start bit, reject glitches
					if (half_end) begin
						clk_cnt <= 16'd0;
						bit_idx <= 3'd0;
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= 16'd0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						beat_valid <= rxd_sync;
						state <= rxd_sync ? RX_IDLE : RX_WAIT;
					end
				end
				RX_WAIT: begin
					// Bad stop bit, hold off until the line is released
					if (rxd_sync)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shift <= {rxd_sync, shift[7:1]};
	end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input wire logic clk,
	input wire logic arst_n,
	input wire uart_cmd_pkg::byte_beat_t tx_beat,
	output logic tx_ready,
	output logic txd
);

	logic busy;
	logic [15:0] clk_cnt;
	logic [3:0] bit_idx;
	logic [8:0] shift;
	logic take;
	logic bit_end;

	assign tx_ready = ~busy;
	assign take = tx_beat.valid & tx_ready;
	assign bit_end = (clk_cnt == uart_cmd_pkg::CLKS_PER_BIT - 16'd1);

	////////////////////////////////////////////////////////////
	// Frame sequencing, bit 0 is start and bit 9 is stop
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			clk_cnt <= 16'd0;
			bit_idx <= 4'd0;
			txd <= 1'b1;
		end else if (take) begin
			busy <= 1'b1;
			clk_cnt <= 16'd0;
			bit_idx <= 4'd0;
			txd <= 1'b0;
		end else if (busy) begin
			if (bit_end) begin
				clk_cnt <= 16'd0;
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
				end else begin
					txd <= shift[0];
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 16'd1;
			end
		end
	end

	// Data bits then the stop bit, shifted out LSB first
	always_ff @(posedge clk) begin
		if (take)
			shift <= {1'b1, tx_beat.data};
		else if (busy && bit_end)
			shift <= {1'b1, shift[8:1]};
	end

endmodule

`default_nettype wire

// ==== testbench/tb_uart_cmd.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart_cmd;

	localparam int CPB = int'(uart_cmd_pkg::CLKS_PER_BIT);
	localparam int NUM_ROWS = 7;
	localparam int ROW_TIMEOUT = 8000;
	localparam int DRIVE_DLY = 1;

	typedef struct packed {
		logic [19:0][7:0] tx_bytes;
		int               n_tx;
		logic             bad_stop;
		int               bad_idx;
		logic [7:0]       exp_leds;
		logic [15:0][7:0] exp_bytes;
		int               n_exp;
	} test_row_t;

	logic clk;
	logic arst_n;
	logic rxd;
	wire logic txd;
	wire logic [7:0] leds;
	logic row_sent;
	int row_idx;
	test_row_t cur;
	test_row_t test_rows [NUM_ROWS];
	logic [31:0] lfsr;
	int rows_checked;
	int pass_count;
	int fail_count;
	int error_count;

	uart_cmd_top uart_cmd_top_inst (
		.clk(clk),
		.arst_n(arst_n),
		.rxd(rxd),
		.txd(txd),
		.leds(leds)
	);

	uart_cmd_checker uart_cmd_checker_inst (
		.clk(clk),
		.arst_n(arst_n),
		.txd(txd),
		.leds(leds),
		.row_sent(row_sent),
		.row_idx(row_idx),
		.exp_bytes(cur.exp_bytes),
		.exp_count(cur.n_exp),
		.exp_leds(cur.exp_leds),
		.rows_checked(rows_checked),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.error_count(error_count)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		int k;
		b = 8'd0;
		for (k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		// A zero would end the string early
		if (b == 8'd0)
			b = 8'd1;
	endtask

	task automatic drive_bit(input logic v);
		#DRIVE_DLY;
		rxd = v;
		repeat (CPB) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b, input logic bad_stop);
		int k;
		drive_bit(1'b0);
		for (k = 0; k < 8; k++)
			drive_bit(b[k]);
		drive_bit(~bad_stop);
		// Idle line lets the receiver leave its error wait
		if (bad_stop) begin
			drive_bit(1'b1);
			drive_bit(1'b1);
		end
	endtask

	task automatic add_tx(input int r, input logic [7:0] b);
		test_rows[r].tx_bytes[test_rows[r].n_tx] = b;
		test_rows[r].n_tx = test_rows[r].n_tx + 1;
	endtask

	task automatic add_exp(input int r, input logic [7:0] b);
		test_rows[r].exp_bytes[test_rows[r].n_exp] = b;
		test_rows[r].n_exp = test_rows[r].n_exp + 1;
	endtask

	////////////////////////////////////////////////////////////
	// Test table
	////////////////////////////////////////////////////////////

	task automatic build_table();
		logic [7:0] payload [18];
		int k;
		for (k = 0; k < NUM_ROWS; k++)
			test_rows[k] = '0;
		for (k = 0; k < 18; k++)
			random_byte(payload[k]);
		// LED set
		add_tx(0, uart_cmd_pkg::OP_LED);
		add_tx(0, 8'hA5);
		test_rows[0].exp_leds = 8'hA5;
		// Store "abc" and read it back twice
		add_tx(1, uart_cmd_pkg::OP_STORE);
		add_tx(1, 8'h61);
		add_tx(1, 8'h62);
		add_tx(1, 8'h63);
		add_tx(1, uart_cmd_pkg::OP_END);
		add_tx(1, uart_cmd_pkg::OP_READBACK);
		add_tx(2, uart_cmd_pkg::OP_READBACK);
		for (k = 1; k < 3; k++) begin
			test_rows[k].exp_leds = 8'hA5;
			add_exp(k, 8'h61);
			add_exp(k, 8'h62);
			add_exp(k, 8'h63);
		end
		// Clear wipes LEDs and buffer
		add_tx(3, uart_cmd_pkg::OP_LED);
		add_tx(3, 8'h3C);
		add_tx(3, uart_cmd_pkg::OP_CLEAR);
		add_tx(3, uart_cmd_pkg::OP_READBACK);
		// Overflow of 18 bytes into 16 entries
		add_tx(4, uart_cmd_pkg::OP_STORE);
		for (k = 0; k < 18; k++)
			add_tx(4, payload[k]);
		add_tx(5, uart_cmd_pkg::OP_END);
		add_tx(5, uart_cmd_pkg::OP_READBACK);
		for (k = 0; k < 16; k++)
			add_exp(5, payload[k]);
		// Unknown opcode then a framing error on an LED opcode
		add_tx(6, 8'h09);
		add_tx(6, uart_cmd_pkg::OP_LED);
		add_tx(6, uart_cmd_pkg::OP_LED);
		add_tx(6, 8'h5A);
		test_rows[6].bad_stop = 1'b1;
		test_rows[6].bad_idx = 1;
		test_rows[6].exp_leds = 8'h5A;
	endtask

	initial begin : run_tests
		int r;
		int i;
		int prev_rows;
		int waited;
		logic hung;
		rxd = 1'b1;
		arst_n = 1'b0;
		row_sent = 1'b0;
		row_idx = 0;
		cur = '0;
		hung = 1'b0;
		lfsr = 32'h541a;
		build_table();
		repeat (5) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		repeat (4) @(posedge clk);
		for (r = 0; r < NUM_ROWS && !hung; r++) begin
			cur = test_rows[r];
			row_idx = r;
			@(posedge clk);
			for (i = 0; i < cur.n_tx; i++)
				send_byte(cur.tx_bytes[i], cur.bad_stop && cur.bad_idx == i);
			prev_rows = rows_checked;
			#DRIVE_DLY;
			row_sent = 1'b1;
			waited = 0;
			while (rows_checked == prev_rows && waited < ROW_TIMEOUT) begin
				@(posedge clk);
				waited++;
			end
			if (rows_checked == prev_rows) begin
				$display("Row %0d: checker did not finish within %0d cycles", r, ROW_TIMEOUT);
				hung = 1'b1;
			end
			#DRIVE_DLY;
			row_sent = 1'b0;
		end
		$display("Rows passed: %0d, failed: %0d, errors: %0d",
			pass_count, fail_count, error_count);
		if (!hung && fail_count == 0 && rows_checked == NUM_ROWS)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/uart_cmd_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_checker (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic txd,
	input wire logic [7:0] leds,
	input wire logic row_sent,
	input int row_idx,
	input wire logic [15:0][7:0] exp_bytes,
	input int exp_count,
	input wire logic [7:0] exp_leds,
	output int rows_checked,
	output int pass_count,
	output int fail_count,
	output int error_count
);

	localparam int CPB = int'(uart_cmd_pkg::CLKS_PER_BIT);

	logic [7:0] frames [$];
	logic frame_busy = 1'b0;
	int framing_errs = 0;
	int rows_q = 0;
	int pass_q = 0;
	int fail_q = 0;
	int error_q = 0;

	assign rows_checked = rows_q;
	assign pass_count = pass_q;
	assign fail_count = fail_q;
	assign error_count = error_q;

	////////////////////////////////////////////////////////////
	// txd frame decoder, sampled mid-bit on the falling edge
	////////////////////////////////////////////////////////////

	initial begin : decode_txd
		logic [7:0] b;
		int k;
		b = 8'd0;
		forever begin
			@(negedge clk);
			if (arst_n && !txd) begin
				frame_busy = 1'b1;
				// Middle of the start bit
				repeat (CPB / 2) @(negedge clk);
				for (k = 0; k < 8; k++) begin
					repeat (CPB) @(negedge clk);
					b[k] = txd;
				end
				repeat (CPB) @(negedge clk);
				if (txd !== 1'b1)
					framing_errs++;
				frames.push_back(b);
				frame_busy = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Per-row comparison
	////////////////////////////////////////////////////////////

	always @(posedge row_sent) begin : check_row
		int errs;
		int waited;
		int limit;
		int k;
		errs = 0;
		waited = 0;
		limit = (exp_count + 2) * 10 * CPB;
		while (frames.size() < exp_count && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (frames.size() < exp_count) begin
			$display("Row %0d: timed out after %0d cycles waiting for %0d txd frames, got %0d",
				row_idx, waited, exp_count, frames.size());
			errs++;
		end
		// No further frame may start for 12 bit times
		repeat (12 * CPB) @(negedge clk);
		if (frames.size() > exp_count || frame_busy) begin
			$display("Row %0d: txd sent more frames than expected", row_idx);
			errs++;
		end
		if (framing_errs != 0) begin
			$display("Row %0d: %0d txd frames had a low stop bit", row_idx, framing_errs);
			errs++;
		end
		for (k = 0; k < exp_count && k < frames.size(); k++) begin
			if (frames[k] !== exp_bytes[k]) begin
				$display("MISMATCH time=%0t signal=txd[%0d] expected=%02h actual=%02h",
					$time, k, exp_bytes[k], frames[k]);
				errs++;
			end
		end
		if (leds !== exp_leds) begin
			$display("MISMATCH time=%0t signal=leds expected=%02h actual=%02h",
				$time, exp_leds, leds);
			errs++;
		end
		frames.delete();
		framing_errs = 0;
		error_q += errs;
		if (errs == 0) begin
			pass_q++;
			$display("Row %0d: ok, %0d frames, leds %02h", row_idx, exp_count, leds);
		end else begin
			fail_q++;
			$display("Row %0d: failed with %0d errors", row_idx, errs);
		end
		rows_q++;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/uart_cmd_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/byte_buffer.sv
src/cmd_ctrl.sv
src/uart_cmd_top.sv
testbench/uart_cmd_checker.sv
testbench/tb_uart_cmd.sv
